// ==== source/memBusPkg.sv ====
`default_nettype none

package memBusPkg;

    // byte address into main memory
    typedef logic [31:0] addrT;

    // one ram byte
    typedef logic [7:0] byteT;

    // instruction or data word
    typedef logic [31:0] wordT;

    // access length in bytes, 1, 2 or 4
    typedef logic [2:0] lenT;

endpackage

`default_nettype wire

// ==== source/accessPkg.sv ====
`default_nettype none

package accessPkg;

    // what the controller is busy with
    typedef enum logic [1:0] {
        IDLE,
        READ_INST,
        READ_DATA,
        WRITE_DATA
    } accessKindT;

    // legal access lengths
    localparam memBusPkg::lenT LEN_BYTE = 3'd1;
    localparam memBusPkg::lenT LEN_HALF = 3'd2;
    localparam memBusPkg::lenT LEN_WORD = 3'd4;

endpackage

`default_nettype wire

// ==== source/byteRam.sv ====
`timescale 1ns/1ns
`default_nettype none

module byteRam #(
    parameter int RAM_ADDR_W = 12
) (
    input  wire                    clk,
    input  wire                    i_we,
    input  wire [RAM_ADDR_W-1:0]   i_addr,
    input  wire memBusPkg::byteT   i_wdata,
    output memBusPkg::byteT        o_rdata
);

    localparam int DEPTH = 1 << RAM_ADDR_W;

    memBusPkg::byteT mem [0:DEPTH-1];

    // write port
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_addr];
    end

endmodule

`default_nettype wire

// ==== source/memController.sv ====
`timescale 1ns/1ns
`default_nettype none

module memController #(
    parameter int RAM_ADDR_W = 12
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    i_ioFull,

    // instruction fetch side
    input  wire                    i_fetchEn,
    input  wire memBusPkg::addrT   i_fetchAddr,
    output logic                   o_fetchDone,
    output memBusPkg::wordT        o_fetchInst,

    // load/store side
    input  wire                    i_dataEn,
    input  wire                    i_dataStore,
    input  wire memBusPkg::lenT    i_dataLen,
    input  wire memBusPkg::addrT   i_dataAddr,
    input  wire memBusPkg::wordT   i_dataWdata,
    output logic                   o_dataDone,
    output memBusPkg::wordT        o_dataRdata,

    // byte ram
    output logic                   o_ramWe,
    output logic [RAM_ADDR_W-1:0]  o_ramAddr,
    output memBusPkg::byteT        o_ramWdata,
    input  wire memBusPkg::byteT   i_ramRdata
);

    accessPkg::accessKindT state;
    logic [2:0]            stage;
    logic [2:0]            lastStage;
    logic                  stageDone;
    logic                  isRead;

    memBusPkg::lenT  len;
    memBusPkg::addrT baseAddr;

    // shared shift buffer
    // reads shift bytes in at the top, writes shift bytes out at the bottom
    memBusPkg::wordT dataBuf;
    memBusPkg::wordT readWord;
    logic [4:0]      readShift;

    assign isRead = (state == accessPkg::READ_INST) || (state == accessPkg::READ_DATA);

    // reads finish one stage after their last address, writes on it
    assign lastStage = (state == accessPkg::WRITE_DATA) ? len - 3'd1 : len;
    assign stageDone = (stage == lastStage);

    // last byte comes straight from the ram
    assign readWord = {i_ramRdata, dataBuf[31:8]};

    always_comb begin
        case (len)
            accessPkg::LEN_BYTE: readShift = 5'd24;
            accessPkg::LEN_HALF: readShift = 5'd16;
            default:             readShift = 5'd0;
        endcase
    end

    // done pulses, held off while the io buffer is full
    assign o_fetchDone = !i_ioFull && (state == accessPkg::READ_INST) && stageDone;
    assign o_fetchInst = readWord;

    assign o_dataDone = !i_ioFull && stageDone &&
                        ((state == accessPkg::READ_DATA) || (state == accessPkg::WRITE_DATA));
    assign o_dataRdata = readWord >> readShift;

    assign o_ramWe    = !i_ioFull && (state == accessPkg::WRITE_DATA);
    assign o_ramWdata = dataBuf[7:0];

    // Stalled: point back at the byte this stage expects, so that
    // i_ramRdata still holds it when the stall lifts.
    assign o_ramAddr = baseAddr[RAM_ADDR_W-1:0] + RAM_ADDR_W'(stage)
                     - RAM_ADDR_W'(i_ioFull);

    // arbitration and stage sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= accessPkg::IDLE;
            stage <= '0;
        end else if (!i_ioFull) begin
            if (state == accessPkg::IDLE) begin
                stage <= '0;
                // data beats fetch
                if (i_dataEn) begin
                    state <= i_dataStore ? accessPkg::WRITE_DATA : accessPkg::READ_DATA;
                end else if (i_fetchEn) begin
                    state <= accessPkg::READ_INST;
                end
            end else if (stageDone) begin
                state <= accessPkg::IDLE;
                stage <= '0;
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    // access payload
    always_ff @(posedge clk) begin
        if (!i_ioFull) begin
            if (state == accessPkg::IDLE) begin
                if (i_dataEn) begin
                    baseAddr <= i_dataAddr;
                    len      <= i_dataLen;
                    dataBuf  <= i_dataWdata;
                end else if (i_fetchEn) begin
                    baseAddr <= i_fetchAddr;
                    len      <= accessPkg::LEN_WORD;
                end
            end else if (isRead || !stageDone) begin
                dataBuf <= readWord;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fetchUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    i_fetchEn,
    input  wire memBusPkg::addrT   i_resetPc,
    input  wire                    i_redirect,
    input  wire memBusPkg::addrT   i_redirectPc,
    input  wire                    i_fetchDone,
    input  wire memBusPkg::wordT   i_fetchInst,
    output logic                   o_fetchEn,
    output memBusPkg::addrT        o_fetchAddr,
    output logic                   o_instValid,
    output memBusPkg::wordT        o_inst,
    output memBusPkg::addrT        o_instPc
);

    memBusPkg::addrT pc;
    logic            kill;

    assign o_fetchAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= i_resetPc;
            o_fetchEn   <= 1'b0;
            kill        <= 1'b0;
            o_instValid <= 1'b0;
        end else begin
            // a killed fetch or one redirected on its done cycle is dropped
            o_instValid <= i_fetchDone && !kill && !i_redirect;
            if (i_fetchDone) begin
                o_fetchEn <= 1'b0;
                kill      <= 1'b0;
                if (i_redirect) begin
                    pc <= i_redirectPc;
                end else if (!kill) begin
                    pc <= pc + 32'd4;
                end
            end else begin
                if (!o_fetchEn) begin
                    o_fetchEn <= i_fetchEn;
                end
                if (i_redirect) begin
                    pc   <= i_redirectPc;
                    kill <= o_fetchEn;
                end
            end
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (i_fetchDone) begin
            o_inst   <= i_fetchInst;
            o_instPc <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== source/dataPort.sv ====
`timescale 1ns/1ns
`default_nettype none

module dataPort (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    i_ldReq,
    input  wire                    i_stReq,
    input  wire memBusPkg::addrT   i_addr,
    input  wire memBusPkg::lenT    i_len,
    input  wire                    i_signed,
    input  wire memBusPkg::wordT   i_wdata,
    input  wire                    i_dataDone,
    input  wire memBusPkg::wordT   i_dataRdata,
    output logic                   o_dataEn,
    output logic                   o_dataStore,
    output memBusPkg::lenT         o_dataLen,
    output memBusPkg::addrT        o_dataAddr,
    output memBusPkg::wordT        o_dataWdata,
    output logic                   o_busy,
    output logic                   o_ldValid,
    output memBusPkg::wordT        o_ldData,
    output logic                   o_stDone
);

    logic            pending;
    logic            cmdSigned;
    memBusPkg::wordT loadExt;

    // request stays up until the controller is done
    assign o_dataEn = pending;
    assign o_busy   = pending;

    // sign extension of narrow loads
    always_comb begin
        loadExt = i_dataRdata;
        if (cmdSigned) begin
            case (o_dataLen)
                accessPkg::LEN_BYTE: loadExt = {{24{i_dataRdata[7]}}, i_dataRdata[7:0]};
                accessPkg::LEN_HALF: loadExt = {{16{i_dataRdata[15]}}, i_dataRdata[15:0]};
                default:             loadExt = i_dataRdata;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            o_ldValid <= 1'b0;
            o_stDone  <= 1'b0;
        end else begin
            o_ldValid <= i_dataDone && !o_dataStore;
            o_stDone  <= i_dataDone && o_dataStore;
            if (!pending && (i_ldReq || i_stReq)) begin
                pending <= 1'b1;
            end else if (i_dataDone) begin
                pending <= 1'b0;
            end
        end
    end

    // latched command
    always_ff @(posedge clk) begin
        if (!pending && (i_ldReq || i_stReq)) begin
            o_dataStore <= i_stReq;
            o_dataLen   <= i_len;
            o_dataAddr  <= i_addr;
            o_dataWdata <= i_wdata;
            cmdSigned   <= i_signed;
        end
        if (i_dataDone) begin
            o_ldData <= loadExt;
        end
    end

endmodule

`default_nettype wire

// ==== source/memSubsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module memSubsystem #(
    parameter int RAM_ADDR_W = 12
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    i_ioFull,
    input  wire                    i_fetchEn,
    input  wire memBusPkg::addrT   i_resetPc,
    input  wire                    i_redirect,
    input  wire memBusPkg::addrT   i_redirectPc,
    output logic                   o_instValid,
    output memBusPkg::wordT        o_inst,
    output memBusPkg::addrT        o_instPc,
    input  wire                    i_ldReq,
    input  wire                    i_stReq,
    input  wire memBusPkg::addrT   i_addr,
    input  wire memBusPkg::lenT    i_len,
    input  wire                    i_signed,
    input  wire memBusPkg::wordT   i_wdata,
    output logic                   o_busy,
    output logic                   o_ldValid,
    output memBusPkg::wordT        o_ldData,
    output logic                   o_stDone
);

    // fetch to controller
    wire                  fetchEn;
    wire memBusPkg::addrT fetchAddr;
    wire                  fetchDone;
    wire memBusPkg::wordT fetchInst;

    // data port to controller
    wire                  dataEn;
    wire                  dataStore;
    wire memBusPkg::lenT  dataLen;
    wire memBusPkg::addrT dataAddr;
    wire memBusPkg::wordT dataWdata;
    wire                  dataDone;
    wire memBusPkg::wordT dataRdata;

    // controller to ram
    wire                  ramWe;
    wire [RAM_ADDR_W-1:0] ramAddr;
    wire memBusPkg::byteT ramWdata;
    wire memBusPkg::byteT ramRdata;

    fetchUnit fetchUnit0 (
        .clk(clk), .rst(rst), .i_fetchEn(i_fetchEn), .i_resetPc(i_resetPc),
        .i_redirect(i_redirect), .i_redirectPc(i_redirectPc),
        .i_fetchDone(fetchDone), .i_fetchInst(fetchInst),
        .o_fetchEn(fetchEn), .o_fetchAddr(fetchAddr),
        .o_instValid(o_instValid), .o_inst(o_inst), .o_instPc(o_instPc)
    );

    dataPort dataPort0 (
        .clk(clk), .rst(rst), .i_ldReq(i_ldReq), .i_stReq(i_stReq),
        .i_addr(i_addr), .i_len(i_len), .i_signed(i_signed), .i_wdata(i_wdata),
        .i_dataDone(dataDone), .i_dataRdata(dataRdata),
        .o_dataEn(dataEn), .o_dataStore(dataStore), .o_dataLen(dataLen),
        .o_dataAddr(dataAddr), .o_dataWdata(dataWdata), .o_busy(o_busy),
        .o_ldValid(o_ldValid), .o_ldData(o_ldData), .o_stDone(o_stDone)
    );

    memController #(.RAM_ADDR_W(RAM_ADDR_W)) memController0 (
        .clk(clk), .rst(rst), .i_ioFull(i_ioFull),
        .i_fetchEn(fetchEn), .i_fetchAddr(fetchAddr),
        .o_fetchDone(fetchDone), .o_fetchInst(fetchInst),
        .i_dataEn(dataEn), .i_dataStore(dataStore), .i_dataLen(dataLen),
        .i_dataAddr(dataAddr), .i_dataWdata(dataWdata),
        .o_dataDone(dataDone), .o_dataRdata(dataRdata),
        .o_ramWe(ramWe), .o_ramAddr(ramAddr), .o_ramWdata(ramWdata),
        .i_ramRdata(ramRdata)
    );

    byteRam #(.RAM_ADDR_W(RAM_ADDR_W)) byteRam0 (
        .clk(clk), .i_we(ramWe), .i_addr(ramAddr),
        .i_wdata(ramWdata), .o_rdata(ramRdata)
    );

endmodule

`default_nettype wire

// ==== verification/memSubsystemTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module memSubsystemTb;

    localparam int RAM_ADDR_W  = 12;
    localparam int MODEL_BYTES = 1 << RAM_ADDR_W;
    localparam int FILL_OPS    = MODEL_BYTES / 4;
    localparam int PAIR_COUNT  = 64;
    localparam int MIX_COUNT   = 400;
    localparam int TOTAL_OPS   = FILL_OPS + 2 * PAIR_COUNT + MIX_COUNT;
    localparam int CYCLE_LIMIT = 40 * TOTAL_OPS + 500;
    // port accept, controller accept, four byte stages, result register
    localparam int WORD_LOAD_LATENCY = 6;
    localparam memBusPkg::addrT RESET_PC = 32'h0000_0200;

    logic            clk;
    logic            rst;
    logic            i_ioFull;
    logic            i_fetchEn;
    memBusPkg::addrT i_resetPc;
    logic            i_redirect;
    memBusPkg::addrT i_redirectPc;
    logic            o_instValid;
    memBusPkg::wordT o_inst;
    memBusPkg::addrT o_instPc;
    logic            i_ldReq;
    logic            i_stReq;
    memBusPkg::addrT i_addr;
    memBusPkg::lenT  i_len;
    logic            i_signed;
    memBusPkg::wordT i_wdata;
    logic            o_busy;
    logic            o_ldValid;
    memBusPkg::wordT o_ldData;
    logic            o_stDone;

    memBusPkg::byteT model [0:MODEL_BYTES-1];
    logic [31:0]     dataRng;
    logic [31:0]     ctlRng;
    logic            fetchOn;
    logic            redirectOn;
    logic            stallOn;
    memBusPkg::addrT expPc;
    int              errCount;
    int              checkCount;
    int              instCount;
    int              redirectCount;
    int              cycleCount;

    memSubsystem #(.RAM_ADDR_W(RAM_ADDR_W)) dut0 (
        .clk(clk), .rst(rst), .i_ioFull(i_ioFull), .i_fetchEn(i_fetchEn),
        .i_resetPc(i_resetPc), .i_redirect(i_redirect), .i_redirectPc(i_redirectPc),
        .o_instValid(o_instValid), .o_inst(o_inst), .o_instPc(o_instPc),
        .i_ldReq(i_ldReq), .i_stReq(i_stReq), .i_addr(i_addr), .i_len(i_len),
        .i_signed(i_signed), .i_wdata(i_wdata), .o_busy(o_busy),
        .o_ldValid(o_ldValid), .o_ldData(o_ldData), .o_stDone(o_stDone)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycleCount);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic takeBits(inout logic [31:0] st, input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            st = lfsrStep(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    function automatic memBusPkg::lenT lenFromBits(input logic [1:0] b);
        if (b == 2'd0) begin
            return accessPkg::LEN_BYTE;
        end
        if (b == 2'd1) begin
            return accessPkg::LEN_HALF;
        end
        return accessPkg::LEN_WORD;
    endfunction

    function automatic memBusPkg::byteT fillByte(input memBusPkg::addrT a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
    endfunction

    // little-endian read of the model, optional sign extension
    function automatic memBusPkg::wordT modelRead(input memBusPkg::addrT a,
                                                  input memBusPkg::lenT len, input logic sgn);
        memBusPkg::wordT v;
        memBusPkg::addrT idx;
        int k;
        v = '0;
        for (k = 0; k < int'(len); k++) begin
            idx = a + k;
            v[8*k +: 8] = model[idx[RAM_ADDR_W-1:0]];
        end
        // bytes above the access copy its top bit
        if (sgn) begin
            for (k = int'(len); k < 4; k++) begin
                v[8*k +: 8] = {8{v[8*int'(len)-1]}};
            end
        end
        return v;
    endfunction

    task automatic modelWrite(input memBusPkg::addrT a, input memBusPkg::lenT len,
                              input memBusPkg::wordT wd);
        memBusPkg::addrT idx;
        int k;
        for (k = 0; k < int'(len); k++) begin
            idx = a + k;
            model[idx[RAM_ADDR_W-1:0]] = wd[8*k +: 8];
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] gotVal);
        checkCount++;
        if (gotVal !== expVal) begin
            errCount++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, expVal, gotVal);
        end
    endtask

    task automatic reportFailure(input string msg);
        errCount++;
        $display("t=%0t %s", $time, msg);
    endtask

    task automatic setMode(input logic f, input logic r, input logic s);
        @(posedge clk);
        fetchOn    = f;
        redirectOn = r;
        stallOn    = s;
    endtask

    // one load or store through the data port, checked on completion
    task automatic doAccess(input logic st, input memBusPkg::addrT a, input memBusPkg::lenT len,
                            input logic sgn, input memBusPkg::wordT wd, input logic timed);
        int   waitCycles;
        logic finished;
        @(negedge clk);
        i_stReq  = st;
        i_ldReq  = !st;
        i_addr   = a;
        i_len    = len;
        i_signed = sgn;
        i_wdata  = wd;
        @(negedge clk);
        i_stReq    = 1'b0;
        i_ldReq    = 1'b0;
        // cycles counted from the edge where the port took the command
        waitCycles = 0;
        finished   = 1'b0;
        while (!finished) begin
            if (o_ldValid || o_stDone) begin
                finished = 1'b1;
                if (o_stDone !== st || o_ldValid !== !st) begin
                    reportFailure("completion pulse does not match the access kind");
                end else if (st) begin
                    modelWrite(a, len, wd);
                end else begin
                    checkValue("o_ldData", modelRead(a, len, sgn), o_ldData);
                    if (timed && len == accessPkg::LEN_WORD && waitCycles != WORD_LOAD_LATENCY) begin
                        reportFailure($sformatf("word load took %0d cycles instead of %0d",
                                                waitCycles, WORD_LOAD_LATENCY));
                    end
                end
                if (o_busy) begin
                    reportFailure("o_busy still high after the access completed");
                end
            end else if (!o_busy) begin
                finished = 1'b1;
                reportFailure("o_busy dropped before the access completed");
            end else begin
                @(negedge clk);
                waitCycles++;
            end
        end
    endtask

    // fetch results are checked before a new redirect moves the expected pc
    always @(negedge clk) begin : fetchAndStallDrive
        logic [31:0] r;
        if (o_instValid) begin
            instCount++;
            checkValue("o_instPc", expPc, o_instPc);
            checkValue("o_inst", modelRead(expPc, accessPkg::LEN_WORD, 1'b0), o_inst);
            expPc = expPc + 32'd4;
        end
        i_fetchEn = fetchOn;
        takeBits(ctlRng, 4, r);
        i_redirect = redirectOn && (r[3:0] == 4'd0);
        if (i_redirect) begin
            takeBits(ctlRng, 32, r);
            i_redirectPc = r & ~32'd3;
            expPc        = i_redirectPc;
            redirectCount++;
        end
        takeBits(ctlRng, 2, r);
        i_ioFull = stallOn && (r[1:0] == 2'd0);
    end

    initial begin : mainSequence
        memBusPkg::addrT a;
        memBusPkg::lenT  len;
        memBusPkg::wordT wd;
        logic [31:0]     r;
        logic            st;
        logic            sgn;
        int              i;
        clk = 1'b0;
        rst = 1'b1;
        i_ioFull     = 1'b0;
        i_fetchEn    = 1'b0;
        i_resetPc    = RESET_PC;
        i_redirect   = 1'b0;
        i_redirectPc = '0;
        i_ldReq      = 1'b0;
        i_stReq      = 1'b0;
        i_addr       = '0;
        i_len        = accessPkg::LEN_WORD;
        i_signed     = 1'b0;
        i_wdata      = '0;
        fetchOn    = 1'b0;
        redirectOn = 1'b0;
        stallOn    = 1'b0;
        expPc      = RESET_PC;
        errCount      = 0;
        checkCount    = 0;
        instCount     = 0;
        redirectCount = 0;
        cycleCount    = 0;
        dataRng = 32'hb67c_0c04;
        // second stream for the fetch and stall driver
        takeBits(dataRng, 32, r);
        ctlRng = r | 32'd1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // whole ram written through the data port first
        for (i = 0; i < FILL_OPS; i++) begin
            a  = 4 * i;
            wd = {fillByte(a + 3), fillByte(a + 2), fillByte(a + 1), fillByte(a)};
            doAccess(1'b1, a, accessPkg::LEN_WORD, 1'b0, wd, 1'b0);
        end

        // store then load back, no fetch and no stalls so latency is exact
        for (i = 0; i < PAIR_COUNT; i++) begin
            takeBits(dataRng, 32, a);
            takeBits(dataRng, 2, r);
            len = lenFromBits(r[1:0]);
            takeBits(dataRng, 32, wd);
            takeBits(dataRng, 1, r);
            doAccess(1'b1, a, len, 1'b0, wd, 1'b1);
            doAccess(1'b0, a, len, r[0], wd, 1'b1);
        end

        // mixed traffic against fetch, redirects and io stalls
        setMode(1'b1, 1'b1, 1'b1);
        for (i = 0; i < MIX_COUNT; i++) begin
            takeBits(dataRng, 1, r);
            st = r[0];
            takeBits(dataRng, 32, a);
            takeBits(dataRng, 2, r);
            len = lenFromBits(r[1:0]);
            takeBits(dataRng, 1, r);
            sgn = r[0];
            takeBits(dataRng, 32, wd);
            doAccess(st, a, len, sgn, wd, 1'b0);
        end
        setMode(1'b0, 1'b0, 1'b0);
        repeat (20) @(negedge clk);

        if (instCount == 0) begin
            reportFailure("no instruction was delivered while fetch was enabled");
        end
        if (redirectCount == 0) begin
            reportFailure("no redirect was issued during the mixed traffic");
        end
        $display("checks %0d, errors %0d, instructions %0d, redirects %0d",
                 checkCount, errCount, instCount, redirectCount);
        if (errCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/memBusPkg.sv
source/accessPkg.sv
source/byteRam.sv
source/memController.sv
source/fetchUnit.sv
source/dataPort.sv
source/memSubsystem.sv
verification/memSubsystemTb.sv
